/* flist.f */
source/ccip_pkg.sv
source/ccip_rx_buffer.sv
source/afu_csr.sv
source/ccip_tx_buffer.sv
source/ccip_std_afu.sv
dv/tb_ccip_std_afu.sv

/* Makefile */
# Verilator build and run for the AFU testbench

VERILATOR ?= verilator
TOP       ?= tb_ccip_std_afu
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG) PASS_MSG="$(PASS_MSG)"

check:
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_ccip_std_afu.sv */
/*
  Testbench for the AFU top level. Builds a table of MMIO steps with the
  expected read data worked out from the register map, then applies it in
  a loop. Reads must answer three edges after the request, for one cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ccip_std_afu;

  import ccip_pkg::*;

  localparam t_mmio_data TB_ID_L = 64'h5a17_c3e9_0b42_d86f;
  localparam t_mmio_data TB_ID_H = 64'he20c_7f31_94ab_6d05;

  typedef enum logic [1:0] {OP_RD, OP_WR, OP_SRST, OP_ERR} t_step_kind;

  // One table row; data is write data for a write and expected data for a read
  typedef struct packed {
    t_step_kind kind;
    t_mmio_addr addr;
    t_mmio_len  len;
    t_mmio_tid  tid;
    logic [1:0] pwr;
    t_mmio_data data;
  } t_step;

  t_step      steps[$];
  logic       pClk, rst_n, soft_reset, host_error, mmio_wr_valid, mmio_rd_valid;
  logic [1:0] pwr_state;
  t_mmio_addr mmio_addr;
  t_mmio_len  mmio_len;
  t_mmio_tid  mmio_tid;
  t_mmio_data mmio_wr_data;
  logic       mmio_rsp_valid;
  t_mmio_tid  mmio_rsp_tid;
  t_mmio_data mmio_rsp_data;

  // Expected register state, tracked while the table is built
  t_mmio_data  m_scratch;
  logic [31:0] m_count;
  logic        m_err;
  logic [1:0]  m_pwr;
  t_mmio_tid   next_tid;
  integer      seed;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  ccip_std_afu #(.AFU_ID_L(TB_ID_L), .AFU_ID_H(TB_ID_H)) dut0 (
    .pClk(pClk), .rst_n(rst_n), .soft_reset(soft_reset), .pwr_state(pwr_state),
    .host_error(host_error), .mmio_wr_valid(mmio_wr_valid),
    .mmio_rd_valid(mmio_rd_valid), .mmio_addr(mmio_addr), .mmio_len(mmio_len),
    .mmio_tid(mmio_tid), .mmio_wr_data(mmio_wr_data),
    .mmio_rsp_valid(mmio_rsp_valid), .mmio_rsp_tid(mmio_rsp_tid),
    .mmio_rsp_data(mmio_rsp_data)
  );

  initial begin
    pClk = 1'b0;
    forever #5 pClk = ~pClk;
  end

  // *********************************************************************
  // Failure reporting and compare tasks
  // *********************************************************************

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(t_mmio_data got, t_mmio_data exp, string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s data %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_tid(t_mmio_tid got, t_mmio_tid exp, string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s tag %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_valid(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, response strobe %b", $time, what, got);
      stop_run();
    end
  endtask

  // The run may not take longer than the table allows
  always @(posedge pClk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_run();
    end
  end

  // *********************************************************************
  // Table building with the expected register model
  // *********************************************************************

  function automatic t_mmio_data expect_read(t_mmio_addr addr, t_mmio_len len);
    t_mmio_data full;
    case (t_csr_idx'(addr[15:1]))
      CSR_DFH:     full = CSR_DFH_VALUE;
      CSR_ID_L:    full = TB_ID_L;
      CSR_ID_H:    full = TB_ID_H;
      CSR_SCRATCH: full = m_scratch;
      CSR_STATUS:  full = {m_count, 29'd0, m_pwr, m_err};
      default:     full = '0;
    endcase
    if (len == MMIO_LEN_32) begin
      full = addr[0] ? {32'd0, full[63:32]} : {32'd0, full[31:0]};
    end
    return full;
  endfunction

  task automatic push_step(t_step_kind kind, t_mmio_addr addr, t_mmio_len len);
    t_step s;
    s.kind = kind;
    s.addr = addr;
    s.len  = len;
    s.tid  = next_tid;
    s.pwr  = m_pwr;
    s.data = '0;
    next_tid = next_tid + 9'd37;
    if (kind == OP_RD) begin
      s.data = expect_read(addr, len);
    end else if (kind == OP_WR) begin
      s.data = {$random(seed), $random(seed)};
      // Any write counts; scratch takes 32-bit data from the low bits
      m_count = m_count + 32'd1;
      if (t_csr_idx'(addr[15:1]) == CSR_SCRATCH) begin
        if (len == MMIO_LEN_64) m_scratch = s.data;
        else if (addr[0]) m_scratch[63:32] = s.data[31:0];
        else m_scratch[31:0] = s.data[31:0];
      end
      if (t_csr_idx'(addr[15:1]) == CSR_STATUS) m_err = 1'b0;
    end else if (kind == OP_SRST) begin
      m_scratch = '0;
      m_count   = '0;
      m_err     = 1'b0;
    end else begin
      m_err = 1'b1;
    end
    steps.push_back(s);
  endtask

  task automatic build_table();
    // Fixed registers, full and one half
    push_step(OP_RD, 16'h0000, MMIO_LEN_64);
    push_step(OP_RD, 16'h0002, MMIO_LEN_64);
    push_step(OP_RD, 16'h0004, MMIO_LEN_64);
    push_step(OP_RD, 16'h0003, MMIO_LEN_32);
    // Scratch with 64-bit and 32-bit accesses
    m_pwr = 2'b01;
    push_step(OP_WR, 16'h0006, MMIO_LEN_64);
    push_step(OP_RD, 16'h0006, MMIO_LEN_64);
    push_step(OP_WR, 16'h0006, MMIO_LEN_32);
    push_step(OP_WR, 16'h0007, MMIO_LEN_32);
    push_step(OP_RD, 16'h0006, MMIO_LEN_32);
    push_step(OP_RD, 16'h0007, MMIO_LEN_32);
    push_step(OP_RD, 16'h0006, MMIO_LEN_64);
    // Unmapped space reads zero, a write there still counts
    push_step(OP_RD, 16'h0040, MMIO_LEN_64);
    push_step(OP_WR, 16'h0052, MMIO_LEN_64);
    push_step(OP_RD, 16'h0041, MMIO_LEN_32);
    // Status with count, power state and the sticky error
    push_step(OP_RD, 16'h0008, MMIO_LEN_64);
    m_pwr = 2'b10;
    push_step(OP_ERR, 16'h0000, MMIO_LEN_64);
    push_step(OP_RD, 16'h0008, MMIO_LEN_64);
    // A write elsewhere must leave the error flag set
    push_step(OP_WR, 16'h0006, MMIO_LEN_32);
    push_step(OP_RD, 16'h0008, MMIO_LEN_32);
    push_step(OP_RD, 16'h0009, MMIO_LEN_32);
    m_pwr = 2'b11;
    push_step(OP_WR, 16'h0008, MMIO_LEN_64);
    push_step(OP_RD, 16'h0008, MMIO_LEN_64);
    // Soft reset clears scratch, count and error, then normal use again
    push_step(OP_ERR, 16'h0000, MMIO_LEN_64);
    push_step(OP_SRST, 16'h0000, MMIO_LEN_64);
    push_step(OP_RD, 16'h0006, MMIO_LEN_64);
    push_step(OP_RD, 16'h0008, MMIO_LEN_64);
    push_step(OP_WR, 16'h0006, MMIO_LEN_64);
    push_step(OP_RD, 16'h0006, MMIO_LEN_64);
    push_step(OP_RD, 16'h0000, MMIO_LEN_64);
  endtask

  // *********************************************************************
  // Step execution
  // *********************************************************************

  task automatic run_step(t_step s);
    @(negedge pClk);
    pwr_state = s.pwr;
    mmio_addr = s.addr;
    mmio_len  = s.len;
    mmio_tid  = s.tid;
    case (s.kind)
      OP_RD:   mmio_rd_valid = 1'b1;
      OP_WR:   mmio_wr_valid = 1'b1;
      OP_SRST: soft_reset = 1'b1;
      default: host_error = 1'b1;
    endcase
    mmio_wr_data = s.data;
    @(negedge pClk);
    mmio_rd_valid = 1'b0;
    mmio_wr_valid = 1'b0;
    soft_reset    = 1'b0;
    host_error    = 1'b0;
    if (s.kind == OP_RD) begin
      check_valid(mmio_rsp_valid, 1'b0, "one edge after read");
      @(negedge pClk);
      check_valid(mmio_rsp_valid, 1'b0, "two edges after read");
      @(negedge pClk);
      check_valid(mmio_rsp_valid, 1'b1, "three edges after read");
      check_tid(mmio_rsp_tid, s.tid, "read response");
      check_data(mmio_rsp_data, s.data, "read response");
      @(negedge pClk);
      check_valid(mmio_rsp_valid, 1'b0, "response held past one cycle");
    end else begin
      repeat (2) begin
        @(negedge pClk);
        check_valid(mmio_rsp_valid, 1'b0, "response without a read");
      end
    end
  endtask

  initial begin
    seed          = 32'h23a;
    m_scratch     = '0;
    m_count       = '0;
    m_err         = 1'b0;
    m_pwr         = 2'b00;
    next_tid      = 9'h011;
    rst_n         = 1'b0;
    soft_reset    = 1'b0;
    host_error    = 1'b0;
    pwr_state     = 2'b00;
    mmio_wr_valid = 1'b0;
    mmio_rd_valid = 1'b0;
    mmio_addr     = '0;
    mmio_len      = MMIO_LEN_64;
    mmio_tid      = '0;
    mmio_wr_data  = '0;
    build_table();
    cycle_limit = 16 + steps.size() * 8 + 50;
    // Reset is sampled low on 16 rising edges, then released on a falling one
    repeat (16) @(posedge pClk);
    @(negedge pClk);
    rst_n = 1'b1;
    // Quiet bus after reset
    repeat (4) begin
      @(negedge pClk);
      check_valid(mmio_rsp_valid, 1'b0, "idle after reset");
    end
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/ccip_std_afu.sv */
/*
  Top level of the AFU. Connects the input buffer, the register file and
  the output buffer and passes the AFU identifier down. A read sampled by
  the input buffer returns on mmio_rsp_valid after three register stages.
  Set AFU_ID_L and AFU_ID_H when instantiating to give the unit its ID.
*/
`timescale 1ns/1ps
`default_nettype none

module ccip_std_afu #(
  parameter ccip_pkg::t_mmio_data AFU_ID_L = 64'h8c2d_41f0_9a37_5e61,
  parameter ccip_pkg::t_mmio_data AFU_ID_H = 64'h3b7e_06d5_c148_a2f9
) (
  input  wire logic                 pClk,
  input  wire logic                 rst_n,
  input  wire logic                 soft_reset,
  input  wire logic [1:0]           pwr_state,
  input  wire logic                 host_error,
  input  wire logic                 mmio_wr_valid,
  input  wire logic                 mmio_rd_valid,
  input  wire ccip_pkg::t_mmio_addr mmio_addr,
  input  wire ccip_pkg::t_mmio_len  mmio_len,
  input  wire ccip_pkg::t_mmio_tid  mmio_tid,
  input  wire ccip_pkg::t_mmio_data mmio_wr_data,
  output logic                      mmio_rsp_valid,
  output ccip_pkg::t_mmio_tid       mmio_rsp_tid,
  output ccip_pkg::t_mmio_data      mmio_rsp_data
);

  import ccip_pkg::*;

  // Registered request from the input side
  logic       afu_rst_n;
  t_mmio_op   req_op;
  t_mmio_addr req_addr;
  t_mmio_len  req_len;
  t_mmio_tid  req_tid;
  t_mmio_data req_wr_data;
  logic [1:0] pwr_state_q;
  logic       host_error_q;

  // Read result from the register file
  logic       rd_valid;
  t_mmio_tid  rd_tid;
  t_mmio_len  rd_len;
  logic       rd_half;
  t_mmio_data rd_data;

  ccip_rx_buffer rx_buf0 (
    .pClk(pClk), .rst_n(rst_n), .soft_reset(soft_reset),
    .mmio_wr_valid(mmio_wr_valid), .mmio_rd_valid(mmio_rd_valid),
    .mmio_addr(mmio_addr), .mmio_len(mmio_len), .mmio_tid(mmio_tid),
    .mmio_wr_data(mmio_wr_data), .pwr_state(pwr_state), .host_error(host_error),
    .afu_rst_n(afu_rst_n), .req_op(req_op), .req_addr(req_addr),
    .req_len(req_len), .req_tid(req_tid), .req_wr_data(req_wr_data),
    .pwr_state_q(pwr_state_q), .host_error_q(host_error_q)
  );

  // The register file runs on the AFU reset, which includes soft reset
  afu_csr #(.AFU_ID_L(AFU_ID_L), .AFU_ID_H(AFU_ID_H)) csr0 (
    .pClk(pClk), .rst_n(afu_rst_n), .req_op(req_op), .req_addr(req_addr),
    .req_len(req_len), .req_tid(req_tid), .req_wr_data(req_wr_data),
    .pwr_state_q(pwr_state_q), .host_error_q(host_error_q),
    .rd_valid(rd_valid), .rd_tid(rd_tid), .rd_len(rd_len),
    .rd_half(rd_half), .rd_data(rd_data)
  );

  ccip_tx_buffer tx_buf0 (
    .pClk(pClk), .rst_n(rst_n), .rd_valid(rd_valid), .rd_tid(rd_tid),
    .rd_len(rd_len), .rd_half(rd_half), .rd_data(rd_data),
    .mmio_rsp_valid(mmio_rsp_valid), .mmio_rsp_tid(mmio_rsp_tid),
    .mmio_rsp_data(mmio_rsp_data)
  );

endmodule

`default_nettype wire

/* source/ccip_tx_buffer.sv */
/*
  Output side of the AFU. Takes the full register value from the register
  file, narrows it for a 32-bit read and registers the MMIO response
  toward the host. The response is a single-cycle strobe and the host
  must take it, since there is no back-pressure on this path.
*/
`timescale 1ns/1ps
`default_nettype none

module ccip_tx_buffer (
  input  wire logic                 pClk,
  input  wire logic                 rst_n,
  input  wire logic                 rd_valid,
  input  wire ccip_pkg::t_mmio_tid  rd_tid,
  input  wire ccip_pkg::t_mmio_len  rd_len,
  input  wire logic                 rd_half,
  input  wire ccip_pkg::t_mmio_data rd_data,
  output logic                      mmio_rsp_valid,
  output ccip_pkg::t_mmio_tid       mmio_rsp_tid,
  output ccip_pkg::t_mmio_data      mmio_rsp_data
);

  import ccip_pkg::*;

  logic [31:0] rd_word;
  t_mmio_data  rsp_data_d;

  // *********************************************************************
  // Response formatting
  // *********************************************************************

  // Address bit 0 picks the upper half of the register
  assign rd_word = rd_half ? rd_data[63:32] : rd_data[31:0];

  // A 32-bit read returns its half in the low bits with the rest zero
  assign rsp_data_d = (rd_len == MMIO_LEN_32) ? {32'd0, rd_word} : rd_data;

  // *********************************************************************
  // Output register
  // *********************************************************************

  // Only the platform reset clears the strobe, soft reset does not reach here
  always_ff @(posedge pClk) begin
    if (!rst_n) begin
      mmio_rsp_valid <= 1'b0;
    end else begin
      mmio_rsp_valid <= rd_valid;
    end
  end

  always_ff @(posedge pClk) begin
    mmio_rsp_tid  <= rd_tid;
    mmio_rsp_data <= rsp_data_d;
  end

endmodule

`default_nettype wire

/* source/afu_csr.sv */
/*
  AFU register file. Decodes registered MMIO writes into the scratch and
  status registers, counts every write, keeps a sticky copy of the host
  error and answers reads one cycle later with the full 64-bit register.
  The tag, size and half select of a read travel with the data so the
  output side can form the host response.
*/
`timescale 1ns/1ps
`default_nettype none

module afu_csr #(
  parameter ccip_pkg::t_mmio_data AFU_ID_L = 64'h0,
  parameter ccip_pkg::t_mmio_data AFU_ID_H = 64'h0
) (
  input  wire logic                 pClk,
  input  wire logic                 rst_n,
  input  wire ccip_pkg::t_mmio_op   req_op,
  input  wire ccip_pkg::t_mmio_addr req_addr,
  input  wire ccip_pkg::t_mmio_len  req_len,
  input  wire ccip_pkg::t_mmio_tid  req_tid,
  input  wire ccip_pkg::t_mmio_data req_wr_data,
  input  wire logic [1:0]           pwr_state_q,
  input  wire logic                 host_error_q,
  output logic                      rd_valid,
  output ccip_pkg::t_mmio_tid       rd_tid,
  output ccip_pkg::t_mmio_len       rd_len,
  output logic                      rd_half,
  output ccip_pkg::t_mmio_data      rd_data
);

  import ccip_pkg::*;

  t_csr_idx   req_idx;
  logic       wr_en;
  logic       rd_en;
  t_mmio_data scratch;
  logic [31:0] wr_count;
  logic       err_sticky;
  t_mmio_data status_word;
  t_mmio_data rd_data_d;

  // Registers are 64 bits wide, so the word address drops its bit 0
  assign req_idx = t_csr_idx'(req_addr[15:1]);
  assign wr_en   = (req_op == MMIO_WR);
  assign rd_en   = (req_op == MMIO_RD);

  // Write count on top, then power state and the sticky error at the bottom
  assign status_word = {wr_count, 29'd0, pwr_state_q, err_sticky};

  // *********************************************************************
  // Write side
  // *********************************************************************

  always_ff @(posedge pClk) begin
    if (!rst_n) begin
      scratch    <= '0;
      wr_count   <= '0;
      err_sticky <= 1'b0;
    end else begin
      // Every write is counted, mapped or not
      if (wr_en) begin
        wr_count <= wr_count + 32'd1;
      end
      if (wr_en && (req_idx == CSR_SCRATCH)) begin
        if (req_len == MMIO_LEN_64) begin
          scratch <= req_wr_data;
        end else if (req_addr[0]) begin
          // A 32-bit write carries its data in the low bits of the bus
          scratch[63:32] <= req_wr_data[31:0];
        end else begin
          scratch[31:0] <= req_wr_data[31:0];
        end
      end
      // A new error in the same cycle as a clear leaves the flag set
      if (host_error_q) begin
        err_sticky <= 1'b1;
      end else if (wr_en && (req_idx == CSR_STATUS)) begin
        err_sticky <= 1'b0;
      end
    end
  end

  // *********************************************************************
  // Read side
  // *********************************************************************

  always_comb begin
    case (req_idx)
      CSR_DFH:     rd_data_d = CSR_DFH_VALUE;
      CSR_ID_L:    rd_data_d = AFU_ID_L;
      CSR_ID_H:    rd_data_d = AFU_ID_H;
      CSR_SCRATCH: rd_data_d = scratch;
      CSR_STATUS:  rd_data_d = status_word;
      // Unmapped index reads as zero
      default:     rd_data_d = '0;
    endcase
  end

  always_ff @(posedge pClk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  // Response payload, qualified by rd_valid downstream
  always_ff @(posedge pClk) begin
    rd_tid  <= req_tid;
    rd_len  <= req_len;
    rd_half <= req_addr[0];
    rd_data <= rd_data_d;
  end

endmodule

`default_nettype wire

/* source/ccip_rx_buffer.sv */
/*
  Input side of the AFU. Every host signal is registered for one cycle
  before the register file sees it. The read and write strobes are merged
  into one opcode with the write taking priority, and the host soft reset
  is turned into the registered reset of the AFU logic.
*/
`timescale 1ns/1ps
`default_nettype none

module ccip_rx_buffer (
  input  wire logic                 pClk,
  input  wire logic                 rst_n,
  input  wire logic                 soft_reset,
  input  wire logic                 mmio_wr_valid,
  input  wire logic                 mmio_rd_valid,
  input  wire ccip_pkg::t_mmio_addr mmio_addr,
  input  wire ccip_pkg::t_mmio_len  mmio_len,
  input  wire ccip_pkg::t_mmio_tid  mmio_tid,
  input  wire ccip_pkg::t_mmio_data mmio_wr_data,
  input  wire logic [1:0]           pwr_state,
  input  wire logic                 host_error,
  output logic                      afu_rst_n,
  output ccip_pkg::t_mmio_op        req_op,
  output ccip_pkg::t_mmio_addr      req_addr,
  output ccip_pkg::t_mmio_len       req_len,
  output ccip_pkg::t_mmio_tid       req_tid,
  output ccip_pkg::t_mmio_data      req_wr_data,
  output logic [1:0]                pwr_state_q,
  output logic                      host_error_q
);

  import ccip_pkg::*;

  // *********************************************************************
  // Control stage
  // *********************************************************************

  // The AFU reset is held low through the platform reset and goes low
  // for every cycle in which the soft reset was sampled high
  always_ff @(posedge pClk) begin
    if (!rst_n) begin
      afu_rst_n    <= 1'b0;
      req_op       <= MMIO_IDLE;
      pwr_state_q  <= 2'b00;
      host_error_q <= 1'b0;
    end else begin
      afu_rst_n    <= ~soft_reset;
      pwr_state_q  <= pwr_state;
      host_error_q <= host_error;
      // A write strobe wins when the host raises both in one cycle
      if (mmio_wr_valid) begin
        req_op <= MMIO_WR;
      end else if (mmio_rd_valid) begin
        req_op <= MMIO_RD;
      end else begin
        req_op <= MMIO_IDLE;
      end
    end
  end

  // Request payload is only looked at when req_op says so
  always_ff @(posedge pClk) begin
    req_addr    <= mmio_addr;
    req_len     <= mmio_len;
    req_tid     <= mmio_tid;
    req_wr_data <= mmio_wr_data;
  end

endmodule

`default_nettype wire

/* source/ccip_pkg.sv */
/*
  Shared MMIO definitions for the AFU register file and its host buffers.
  Holds the address, tag and data types of an MMIO request, the opcode and
  access-size enums, the register index map and the fixed feature header.
  Every RTL file imports what it uses from here; the testbench reads the
  feature-header value from here as well.
*/
`default_nettype none

package ccip_pkg;

  // *********************************************************************
  // MMIO transaction fields
  // *********************************************************************

  // Address in 32-bit word units, so bit 0 picks the half of a 64-bit CSR
  typedef logic [15:0] t_mmio_addr;

  // Tag that the host attaches to a read and the response echoes back
  typedef logic [8:0]  t_mmio_tid;

  // Data word of a request or a response
  typedef logic [63:0] t_mmio_data;

  // Request kind after the two host strobes are merged
  typedef enum logic [1:0] {
    MMIO_IDLE = 2'd0,
    MMIO_RD   = 2'd1,
    MMIO_WR   = 2'd2
  } t_mmio_op;

  // Access size of a request
  typedef enum logic {
    MMIO_LEN_32 = 1'b0,
    MMIO_LEN_64 = 1'b1
  } t_mmio_len;

  // *********************************************************************
  // Register map, indexed by the address without its bit 0
  // *********************************************************************

  typedef enum logic [14:0] {
    CSR_DFH     = 15'd0,
    CSR_ID_L    = 15'd1,
    CSR_ID_H    = 15'd2,
    CSR_SCRATCH = 15'd3,
    CSR_STATUS  = 15'd4
  } t_csr_idx;

  // Feature header: AFU type in bits 63:60, end-of-list flag in bit 40
  localparam t_mmio_data CSR_DFH_VALUE = 64'h1000_0100_0000_0000;

endpackage

`default_nettype wire
